//--- hdl/uart_word_rx_params.svh
`ifndef UART_WORD_RX_PARAMS_SVH
`define UART_WORD_RX_PARAMS_SVH

////////////////////
// Serial bit timing
////////////////////

// Clock cycles per serial bit, kept even so the half period is exact
`define CLKS_PER_BIT 16

////////////////////
// Word FIFO sizing
////////////////////

// Words held in the receive FIFO, a power of two
`define FIFO_DEPTH 8

// Count width holds 0 up to FIFO_DEPTH inclusive
`define FIFO_CNT_W 4

`endif

//--- hdl/uart_word_rx_pkg.sv
`include "uart_word_rx_params.svh"

package uart_word_rx_pkg;

    ////////////////////
    // Register map
    ////////////////////
    localparam logic [3:0] ADDR_DATA   = 4'h0;  // Head word, read pops
    localparam logic [3:0] ADDR_STATUS = 4'h4;  // FIFO state and error flags
    localparam logic [3:0] ADDR_CTRL   = 4'h8;  // Bit 0 clears held flags

    ////////////////////
    // Bus and status types
    ////////////////////
    typedef struct packed {
        logic        psel;     // Slave selected
        logic        penable;  // Access phase
        logic        pwrite;   // Write when high
        logic [3:0]  paddr;    // Byte offset
        logic [31:0] pwdata;   // Write data
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;   // Read data
        logic        pready;   // Transfer done
        logic        pslverr;  // Bad offset
    } apb_rsp_t;

    typedef struct packed {
        logic [`FIFO_CNT_W-1:0] count;     // Words stored
        logic                   full;      // No room left
        logic                   empty;     // Nothing to read
        logic                   overflow;  // Word lost, sticky
    } fifo_stat_t;

    typedef struct packed {
        logic       valid;  // One cycle strobe
        logic [7:0] data;   // Received byte
    } rx_byte_t;

endpackage

//--- hdl/baud_timer.sv
`timescale 1ns/100ps
`include "uart_word_rx_params.svh"

module baud_timer (
    input  logic clk,
    input  logic arst_n,
    input  logic start,   // Restart at a detected start edge
    output logic tick     // Bit centre strobe
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);  // Counter width

    localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(`CLKS_PER_BIT / 2 - 1);  // To mid start bit
    localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(`CLKS_PER_BIT - 1);      // One bit period

    logic [CNT_W-1:0] cnt;  // Cycles left to next tick

    ////////////////////
    // Down counter
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= FULL_LOAD;                // Free run from reset
        end else if (start) begin
            cnt <= HALF_LOAD;                // Half period to land mid start bit
        end else if (cnt == '0) begin
            cnt <= FULL_LOAD;                // Next bit centre
        end else begin
            cnt <= cnt - 1'b1;               // Count down
        end
    end

    // Tick when the count expires, never in the restart cycle
    assign tick = (cnt == '0) && !start;

endmodule

//--- hdl/uart_rx_fsm.sv
`timescale 1ns/100ps

module uart_rx_fsm (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      rx,           // Serial line, idle high
    input  logic                      tick,         // Bit centre strobe
    output logic                      baud_start,   // Restart the baud timer
    output uart_word_rx_pkg::rx_byte_t rx_byte,     // Received byte and strobe
    input  logic                      clear_err,    // Clear held frame error
    output logic                      frame_error   // Bad stop bit seen, sticky
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t     state;       // Receive state
    logic       rx_meta;     // First sync stage
    logic       rx_sync;     // Second sync stage
    logic       rx_prev;     // Delayed copy for edge detect
    logic       fall;        // Falling edge on synced line
    logic [2:0] bit_idx;     // Data bit position
    logic [7:0] shift;       // Data bits, LSB first
    logic       byte_valid;  // Good stop bit strobe
    logic [7:0] byte_data;   // Captured byte

    ////////////////////
    // Input synchronizer
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;                 // Line idles high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall       = rx_prev && !rx_sync;           // High to low on the line
    assign baud_start = (state == IDLE) && fall;       // Align timer to the start edge

    ////////////////////
    // Receive state machine
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            bit_idx     <= '0;
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid <= 1'b0;                        // Strobe lasts one cycle
            if (clear_err)
                frame_error <= 1'b0;                   // Host clear, a new error below wins
            case (state)
                IDLE: begin
                    if (fall)
                        state <= START;
                end
                START: begin
                    if (tick) begin
                        if (rx_sync) begin
                            state <= IDLE;             // Glitch, no real start bit
                        end else begin
                            state   <= DATA;
                            bit_idx <= '0;
                        end
                    end
                end
                DATA: begin
                    if (tick) begin
                        if (bit_idx == 3'd7)
                            state <= STOP;             // Eighth bit taken
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                STOP: begin
                    if (tick) begin
                        state <= IDLE;
                        if (rx_sync)
                            byte_valid <= 1'b1;        // Clean frame
                        else
                            frame_error <= 1'b1;       // Byte dropped
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (state == DATA && tick)
            shift <= {rx_sync, shift[7:1]};            // LSB arrives first
        if (state == STOP && tick && rx_sync)
            byte_data <= shift;                        // Hold with the strobe
    end

    assign rx_byte = '{valid: byte_valid, data: byte_data};

endmodule

//--- hdl/byte_packer.sv
`timescale 1ns/100ps

module byte_packer (
    input  logic                      clk,
    input  logic                      arst_n,
    input  uart_word_rx_pkg::rx_byte_t rx_byte,     // Byte strobe from receiver
    output logic [31:0]               word,         // Packed word, first byte on top
    output logic                      word_valid    // Word complete strobe
);

    logic [1:0] byte_cnt;  // Bytes in the current word

    ////////////////////
    // Byte counter
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            byte_cnt   <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= rx_byte.valid && (byte_cnt == 2'd3);  // Fourth byte lands
            if (rx_byte.valid)
                byte_cnt <= byte_cnt + 1'b1;                    // Wraps after four
        end
    end

    // Shift left so older bytes move up
    always_ff @(posedge clk) begin
        if (rx_byte.valid)
            word <= {word[23:0], rx_byte.data};  // New byte at the low end
    end

endmodule

//--- hdl/word_fifo.sv
`timescale 1ns/100ps
`include "uart_word_rx_params.svh"

module word_fifo (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        push,    // Word strobe from packer
    input  logic [31:0]                 wdata,   // Word to store
    input  logic                        pop,     // Remove head word
    input  logic                        clear,   // Clear sticky overflow
    output logic [31:0]                 head,    // Oldest word
    output uart_word_rx_pkg::fifo_stat_t stat    // Count and flags
);

    localparam int AW = $clog2(`FIFO_DEPTH);  // Pointer width
    localparam int CW = `FIFO_CNT_W;          // Count width

    logic [31:0]   mem [`FIFO_DEPTH];  // Word storage
    logic [AW-1:0] wr_ptr;             // Next free slot
    logic [AW-1:0] rd_ptr;             // Head slot
    logic [CW-1:0] count;              // Words stored
    logic          full;
    logic          empty;
    logic          overflow;           // Sticky lost word flag
    logic          do_push;            // Accepted write
    logic          do_pop;             // Accepted read

    assign full    = (count == CW'(`FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;    // Dropped when full
    assign do_pop  = pop && !empty;    // Ignored when empty

    ////////////////////
    // Pointers and count
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;            // Wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Both or neither
            endcase
            if (clear)
                overflow <= 1'b0;
            if (push && full)
                overflow <= 1'b1;                   // Set beats clear
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= wdata;
    end

    assign head = mem[rd_ptr];                      // Show-ahead read
    assign stat = '{count: count, full: full, empty: empty, overflow: overflow};

endmodule

//--- hdl/apb_regs.sv
`timescale 1ns/100ps

module apb_regs (
    input  logic                        clk,
    input  logic                        arst_n,
    input  uart_word_rx_pkg::apb_req_t  apb_req,      // From bus master
    output uart_word_rx_pkg::apb_rsp_t  apb_rsp,      // To bus master
    input  logic [31:0]                 head,         // FIFO head word
    input  uart_word_rx_pkg::fifo_stat_t fifo_stat,   // FIFO state
    input  logic                        frame_error,  // Receiver error flag
    output logic                        pop,          // Take head word
    output logic                        clear_err     // Clear held flags
);

    import uart_word_rx_pkg::*;

    logic        setup_q;    // Setup phase seen last cycle
    logic        access;     // Valid access phase
    logic        sel_data;
    logic        sel_status;
    logic        sel_ctrl;
    logic [31:0] status;     // Packed status word
    logic [31:0] rdata;      // Read mux

    ////////////////////
    // Phase tracking
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            setup_q <= 1'b0;
        else
            setup_q <= apb_req.psel && !apb_req.penable;  // Setup precedes access
    end

    assign access     = setup_q && apb_req.psel && apb_req.penable;
    assign sel_data   = (apb_req.paddr == ADDR_DATA);
    assign sel_status = (apb_req.paddr == ADDR_STATUS);
    assign sel_ctrl   = (apb_req.paddr == ADDR_CTRL);

    // Flags above the count
    assign status = {24'd0, frame_error, fifo_stat.overflow, fifo_stat.full,
                     fifo_stat.empty, fifo_stat.count};

    always_comb begin
        rdata = '0;                                      // Idle and bad offsets read 0
        if (access && !apb_req.pwrite) begin
            if (sel_data && !fifo_stat.empty)
                rdata = head;
            else if (sel_status)
                rdata = status;
        end
    end

    // Side effects take hold at the edge ending the access
    assign pop       = access && !apb_req.pwrite && sel_data && !fifo_stat.empty;
    assign clear_err = access && apb_req.pwrite && sel_ctrl && apb_req.pwdata[0];

    assign apb_rsp = '{prdata:  rdata,
                       pready:  1'b1,                    // No wait states
                       pslverr: access && !(sel_data || sel_status || sel_ctrl)};

endmodule

//--- hdl/uart_word_rx.sv
`timescale 1ns/100ps

module uart_word_rx (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       rx,       // Serial input, 8N1
    input  uart_word_rx_pkg::apb_req_t apb_req,  // Host bus in
    output uart_word_rx_pkg::apb_rsp_t apb_rsp   // Host bus out
);

    import uart_word_rx_pkg::*;

    logic        baud_start;   // Timer restart
    logic        tick;         // Bit centre strobe
    rx_byte_t    rx_byte;      // Received byte
    logic        frame_error;  // Sticky stop bit error
    logic [31:0] word;         // Packed word
    logic        word_valid;   // Word ready for FIFO
    logic [31:0] head;         // FIFO head
    fifo_stat_t  fifo_stat;    // FIFO status
    logic        pop;          // DATA read
    logic        clear_err;    // CTRL clear

    ////////////////////
    // Serial receive
    ////////////////////
    baud_timer baud_timer_i (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (baud_start),
        .tick   (tick)
    );

    uart_rx_fsm uart_rx_fsm_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .rx          (rx),
        .tick        (tick),
        .baud_start  (baud_start),
        .rx_byte     (rx_byte),
        .clear_err   (clear_err),
        .frame_error (frame_error)
    );

    ////////////////////
    // Word path and host
    ////////////////////
    byte_packer byte_packer_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .rx_byte    (rx_byte),
        .word       (word),
        .word_valid (word_valid)
    );

    word_fifo word_fifo_i (
        .clk    (clk),
        .arst_n (arst_n),
        .push   (word_valid),
        .wdata  (word),
        .pop    (pop),
        .clear  (clear_err),      // Same clear as the frame error
        .head   (head),
        .stat   (fifo_stat)
    );

    apb_regs apb_regs_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .head        (head),
        .fifo_stat   (fifo_stat),
        .frame_error (frame_error),
        .pop         (pop),
        .clear_err   (clear_err)
    );

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk  // Free running testbench clock
);

    localparam int HALF_PERIOD = 50;  // 100 ns period

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

//--- verif/uart_word_rx_tb.sv
`timescale 1ns/100ps
`include "uart_word_rx_params.svh"

module uart_word_rx_tb;

    import uart_word_rx_pkg::*;

    localparam int CLK_PERIOD  = 100;  // ns
    localparam int SAMPLE_DLY  = 10;   // Sample point after the falling edge
    localparam int POLL_MAX    = 50;   // STATUS reads before giving up
    localparam int NUM_FRAMES  = 65;   // Serial frames over all tests
    localparam int WATCHDOG_NS = 2 * NUM_FRAMES * 10 * `CLKS_PER_BIT * CLK_PERIOD + 100_000;

    logic        clk;
    logic        arst_n;
    logic        rx;          // Serial line to DUT
    apb_req_t    apb_req;     // Host bus request
    apb_rsp_t    apb_rsp;     // Host bus response
    logic [31:0] exp_q [$];   // Words expected from DATA reads
    logic [31:0] got_q [$];   // Words returned by DATA reads

    tb_clk_gen tb_clk_gen_i (.clk(clk));

    uart_word_rx uart_word_rx_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .rx      (rx),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    ////////////////////
    // Reference model
    ////////////////////
    function automatic logic [31:0] pack_word(input logic [7:0] b0, input logic [7:0] b1,
                                              input logic [7:0] b2, input logic [7:0] b3);
        return {b0, b1, b2, b3};  // First byte on top
    endfunction

    function automatic logic [31:0] exp_status(input int cnt, input bit ov, input bit fe);
        logic [31:0] s;
        s      = '0;
        s[3:0] = cnt[3:0];               // Count
        s[4]   = (cnt == 0);             // Empty
        s[5]   = (cnt == `FIFO_DEPTH);   // Full
        s[6]   = ov;
        s[7]   = fe;
        return s;
    endfunction

    ////////////////////
    // Failure and checks
    ////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            abort_run("Value mismatch");
        end
    endtask

    ////////////////////
    // Serial stimulus
    ////////////////////
    task automatic drive_bit(input logic v);
        rx = v;                                  // Called on a falling edge
        repeat (`CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b, input logic stop);
        drive_bit(1'b0);                         // Start bit
        for (int i = 0; i < 8; i++)
            drive_bit(b[i]);                     // LSB first
        drive_bit(stop);
        if (!stop)
            drive_bit(1'b1);                     // Line back to idle after a bad stop
    endtask

    task automatic send_word(input bit kept);
        logic [7:0] b [4];
        for (int i = 0; i < 4; i++) begin
            b[i] = 8'($urandom);
            send_byte(b[i], 1'b1);
        end
        if (kept)
            exp_q.push_back(pack_word(b[0], b[1], b[2], b[3]));  // Dropped word not queued
    endtask

    ////////////////////
    // APB host
    ////////////////////
    task automatic apb_xfer(input bit wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        apb_req.psel    = 1'b1;                  // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;                  // Access phase, pready always high
        #SAMPLE_DLY;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_val("pready", 32'(apb_rsp.pready), 32'd1);
        @(negedge clk);
        apb_req = '0;                            // Bus idle
    endtask

    task automatic read_word();
        logic [31:0] d;
        logic        e;
        apb_xfer(1'b0, ADDR_DATA, '0, d, e);
        got_q.push_back(d);                      // Checked by the compare process
    endtask

    task automatic expect_status(input logic [31:0] exp);
        logic [31:0] s;
        logic        e;
        apb_xfer(1'b0, ADDR_STATUS, '0, s, e);
        check_val("status", s, exp);
    endtask

    task automatic wait_count(input int target);
        logic [31:0] s;
        logic        e;
        int          polls;
        polls = 0;
        apb_xfer(1'b0, ADDR_STATUS, '0, s, e);
        while (s[3:0] != target[3:0]) begin
            if (polls == POLL_MAX)
                abort_run("FIFO count never reached the expected number of words");
            else begin
                polls++;
                apb_xfer(1'b0, ADDR_STATUS, '0, s, e);
            end
        end
    endtask

    // Compare every DATA read with the oldest expected word
    always @(posedge clk) begin
        while (got_q.size() != 0) begin
            if (exp_q.size() == 0)
                abort_run("DATA read returned a word that was never expected");
            else
                check_val("prdata", got_q.pop_front(), exp_q.pop_front());
        end
    end

    // Watchdog
    initial begin
        #WATCHDOG_NS;
        abort_run("Timeout, the watchdog expired before all tests finished");
    end

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        logic [31:0] d;
        logic        e;
        arst_n  = 1'b0;
        rx      = 1'b1;                          // Line idles high
        apb_req = '0;
        void'($urandom(73));
        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        // Reset state and empty DATA read
        expect_status(exp_status(0, 1'b0, 1'b0));
        apb_xfer(1'b0, ADDR_DATA, '0, d, e);
        check_val("prdata", d, 32'd0);
        check_val("pslverr", 32'(e), 32'd0);

        // One word
        send_word(1'b1);
        wait_count(1);
        read_word();
        expect_status(exp_status(0, 1'b0, 1'b0));

        // Five words back to back
        for (int i = 0; i < 5; i++)
            send_word(1'b1);
        wait_count(5);
        read_word();
        read_word();
        expect_status(exp_status(3, 1'b0, 1'b0));
        repeat (3) read_word();
        expect_status(exp_status(0, 1'b0, 1'b0));

        // Overflow, the ninth word is lost
        for (int i = 0; i < 9; i++)
            send_word(i < `FIFO_DEPTH);
        wait_count(`FIFO_DEPTH);
        expect_status(exp_status(`FIFO_DEPTH, 1'b1, 1'b0));
        repeat (`FIFO_DEPTH) read_word();
        apb_xfer(1'b0, ADDR_DATA, '0, d, e);     // Head slot still holds a stale word
        check_val("prdata", d, 32'd0);
        check_val("pslverr", 32'(e), 32'd0);
        expect_status(exp_status(0, 1'b1, 1'b0));
        apb_xfer(1'b1, ADDR_CTRL, 32'h1, d, e);
        expect_status(exp_status(0, 1'b0, 1'b0));

        // Bad stop bit, byte dropped
        send_byte(8'($urandom), 1'b0);
        expect_status(exp_status(0, 1'b0, 1'b1));
        send_word(1'b1);
        wait_count(1);
        expect_status(exp_status(1, 1'b0, 1'b1));

        // Unmapped offset, stored word and held flag stay put
        apb_xfer(1'b0, 4'hC, '0, d, e);
        check_val("prdata", d, 32'd0);
        check_val("pslverr", 32'(e), 32'd1);
        apb_xfer(1'b1, 4'hC, 32'hFFFF_FFFF, d, e);
        check_val("prdata", d, 32'd0);
        check_val("pslverr", 32'(e), 32'd1);
        expect_status(exp_status(1, 1'b0, 1'b1));

        read_word();
        apb_xfer(1'b1, ADDR_CTRL, 32'h1, d, e);
        expect_status(exp_status(0, 1'b0, 1'b0));

        @(negedge clk);                          // Let the last compare run
        if (exp_q.size() == 0 && got_q.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else
            abort_run("Some expected words were never read back");
    end

endmodule

//--- uart_word_rx.f
+incdir+hdl
hdl/uart_word_rx_pkg.sv
hdl/baud_timer.sv
hdl/uart_rx_fsm.sv
hdl/byte_packer.sv
hdl/word_fifo.sv
hdl/apb_regs.sv
hdl/uart_word_rx.sv
verif/tb_clk_gen.sv
verif/uart_word_rx_tb.sv

//--- run.sh
#!/bin/bash
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module uart_word_rx_tb -f uart_word_rx.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "All tests passed" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
